/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= tb_hb_axi_frontend
RTL_TOP   ?= hb_axi_frontend
FILELIST  ?= hb_axi_frontend.f

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Regression passed"

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf obj_dir

/* hb_axi_frontend.f */
+incdir+.
hb_cfg_pkg.sv
hb_proto_pkg.sv
hb_cmd_if.sv
hb_cmd_path.sv
hb_rx_path.sv
hb_tx_path.sv
hb_trans_ctrl.sv
hb_axi_frontend.sv
tb_hb_axi_frontend.sv

/* hb_axi_frontend.sv */
`timescale 1ns/1ps
// ========================================
// AXI4 to HyperBus front end, top level
// ========================================
module hb_axi_frontend #(
    parameter int unsigned NumChips     = hb_cfg_pkg::NumChips,
    parameter int unsigned ChipAddrBits = hb_cfg_pkg::ChipAddrBits
) (
    input  logic                                  clk_i,
    input  logic                                  rst_ni,
    // AXI write address
    input  logic                                  aw_valid_i,
    output logic                                  aw_ready_o,
    input  hb_cfg_pkg::axi_addr_t                 aw_addr_i,
    input  logic [7:0]                            aw_len_i,
    input  logic [2:0]                            aw_size_i,
    input  logic [1:0]                            aw_burst_i,
    // AXI read address
    input  logic                                  ar_valid_i,
    output logic                                  ar_ready_o,
    input  hb_cfg_pkg::axi_addr_t                 ar_addr_i,
    input  logic [7:0]                            ar_len_i,
    input  logic [2:0]                            ar_size_i,
    input  logic [1:0]                            ar_burst_i,
    // AXI W, R and B
    input  logic                                  w_valid_i,
    output logic                                  w_ready_o,
    input  hb_cfg_pkg::axi_data_t                 w_data_i,
    input  logic [hb_cfg_pkg::AxiDataWidth/8-1:0] w_strb_i,
    input  logic                                  w_last_i,
    output logic                                  r_valid_o,
    input  logic                                  r_ready_i,
    output hb_cfg_pkg::axi_data_t                 r_data_o,
    output hb_proto_pkg::hb_resp_e                r_resp_o,
    output logic                                  r_last_o,
    output logic                                  b_valid_o,
    input  logic                                  b_ready_i,
    output hb_proto_pkg::hb_resp_e                b_resp_o,
    // PHY
    input  logic                                  rx_valid_i,
    output logic                                  rx_ready_o,
    input  hb_cfg_pkg::phy_data_t                 rx_data_i,
    input  logic                                  rx_last_i,
    input  logic                                  rx_error_i,
    output logic                                  tx_valid_o,
    input  logic                                  tx_ready_i,
    output hb_cfg_pkg::phy_data_t                 tx_data_o,
    output hb_cfg_pkg::phy_strb_t                 tx_strb_o,
    output logic                                  tx_last_o,
    input  logic                                  b_valid_i,
    output logic                                  b_ready_o,
    input  logic                                  b_error_i,
    output hb_proto_pkg::hb_trans_t               trans_o,
    output logic [NumChips-1:0]                   trans_cs_o,
    output logic                                  trans_valid_o,
    input  logic                                  trans_ready_i,
    // Configuration and status
    input  logic [4:0]                            addr_mask_msb_i,
    input  logic                                  addr_space_i,
    output logic                                  trans_active_o
);
    import hb_proto_pkg::*;

    logic wr_en;
    logic rx_done;
    logic tx_done;
    logic b_done;

    hb_cmd_if cmd ();

    // Completion events
    assign rx_done = rx_valid_i & rx_ready_o & rx_last_i;
    assign tx_done = tx_valid_o & tx_ready_i & tx_last_o;
    assign b_done  = b_valid_i & b_ready_i;

    // B passes straight through
    assign b_valid_o = b_valid_i;
    assign b_ready_o = b_ready_i;
    assign b_resp_o  = b_error_i ? HB_RESP_SLVERR : HB_RESP_OKAY;

    hb_cmd_path #(
        .NumChips     ( NumChips     ),
        .ChipAddrBits ( ChipAddrBits )
    ) i_cmd_path (
        .clk_i, .rst_ni,
        .aw_valid_i, .aw_ready_o, .aw_addr_i, .aw_len_i, .aw_size_i, .aw_burst_i,
        .ar_valid_i, .ar_ready_o, .ar_addr_i, .ar_len_i, .ar_size_i, .ar_burst_i,
        .busy_i          ( trans_active_o ),
        .addr_mask_msb_i, .addr_space_i,
        .trans_o, .trans_cs_o, .trans_valid_o, .trans_ready_i,
        .cmd             ( cmd.source     )
    );

    hb_rx_path i_rx_path (
        .clk_i, .rst_ni,
        .rx_valid_i, .rx_ready_o, .rx_data_i, .rx_last_i, .rx_error_i,
        .r_valid_o, .r_ready_i, .r_data_o, .r_resp_o, .r_last_o,
        .cmd             ( cmd.sink       )
    );

    hb_tx_path i_tx_path (
        .clk_i, .rst_ni,
        .w_valid_i, .w_ready_o, .w_data_i, .w_strb_i, .w_last_i,
        .tx_valid_o, .tx_ready_i, .tx_data_o, .tx_strb_o, .tx_last_o,
        .wr_en_i         ( wr_en          ),
        .cmd             ( cmd.sink       )
    );

    hb_trans_ctrl i_trans_ctrl (
        .clk_i, .rst_ni,
        .rx_done_i       ( rx_done        ),
        .tx_done_i       ( tx_done        ),
        .b_done_i        ( b_done         ),
        .busy_o          ( trans_active_o ),
        .wr_en_o         ( wr_en          ),
        .cmd             ( cmd.sink       )
    );

endmodule

/* hb_cfg_pkg.sv */
// ========================================
// Widths, derived sizes and word types
// of the AXI to HyperBus front end
// ========================================
package hb_cfg_pkg;

    // Bus widths
    localparam int unsigned AxiDataWidth = 32;
    localparam int unsigned AxiAddrWidth = 32;
    localparam int unsigned PhyWidth     = 16;

    // Chip defaults, overridden from the top level
    localparam int unsigned NumChips     = 2;
    localparam int unsigned ChipAddrBits = 20;

    // PHY words in one full AXI beat
    localparam int unsigned WordsPerBeat = AxiDataWidth / PhyWidth;

    typedef logic [AxiAddrWidth-1:0] axi_addr_t;
    typedef logic [AxiDataWidth-1:0] axi_data_t;
    typedef logic [PhyWidth-1:0]     phy_data_t;
    typedef logic [PhyWidth/8-1:0]   phy_strb_t;

    // Burst length in 16-bit words
    typedef logic [15:0] hb_blen_t;

endpackage

/* hb_cmd_if.sv */
`timescale 1ns/1ps
// ========================================
// Accepted command, shared by datapaths
// ========================================
interface hb_cmd_if;
    import hb_proto_pkg::*;

    logic       cmd_valid;
    hb_op_e     op;
    // AXI size, 1 or 2
    logic [2:0] size;
    // Address bit 1, the starting halfword
    logic       lane;
    // AXI len plus one
    logic [8:0] beats;
    // Pulse on the trans handshake
    logic       start;

    modport source (output cmd_valid, op, size, lane, beats, start);
    modport sink   (input  cmd_valid, op, size, lane, beats, start);

endinterface

/* hb_cmd_path.sv */
`timescale 1ns/1ps
// ========================================
// AR/AW round-robin arbiter, command
// register and descriptor conversion
// ========================================
module hb_cmd_path #(
    parameter int unsigned NumChips     = hb_cfg_pkg::NumChips,
    parameter int unsigned ChipAddrBits = hb_cfg_pkg::ChipAddrBits
) (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    aw_valid_i,
    output logic                    aw_ready_o,
    input  hb_cfg_pkg::axi_addr_t   aw_addr_i,
    input  logic [7:0]              aw_len_i,
    input  logic [2:0]              aw_size_i,
    input  logic [1:0]              aw_burst_i,
    input  logic                    ar_valid_i,
    output logic                    ar_ready_o,
    input  hb_cfg_pkg::axi_addr_t   ar_addr_i,
    input  logic [7:0]              ar_len_i,
    input  logic [2:0]              ar_size_i,
    input  logic [1:0]              ar_burst_i,
    input  logic                    busy_i,
    input  logic [4:0]              addr_mask_msb_i,
    input  logic                    addr_space_i,
    output hb_proto_pkg::hb_trans_t trans_o,
    output logic [NumChips-1:0]     trans_cs_o,
    output logic                    trans_valid_o,
    input  logic                    trans_ready_i,
    hb_cmd_if.source                cmd
);
    import hb_cfg_pkg::*;
    import hb_proto_pkg::*;

    logic       cmd_valid_q;
    hb_op_e     op_q;
    axi_addr_t  addr_q;
    logic [7:0] len_q;
    logic [2:0] size_q;
    logic       idle;
    logic       gnt_w;
    logic       gnt_r;
    logic       ax_hs;
    logic       trans_hs;
    axi_addr_t  sel_addr;
    logic [2:0] sel_size;
    hb_burst_e  sel_burst;
    logic [8:0] beats;
    axi_addr_t  chip_idx;

    // ========================================
    // Arbitration
    // ========================================

    // Opposite side of the last grant wins a tie
    assign idle       = ~cmd_valid_q & ~busy_i;
    assign gnt_w      = aw_valid_i & (~ar_valid_i | (op_q == HB_OP_READ));
    assign gnt_r      = ar_valid_i & ~gnt_w;
    assign aw_ready_o = idle & gnt_w;
    assign ar_ready_o = idle & gnt_r;
    assign ax_hs      = aw_ready_o | ar_ready_o;

    assign sel_addr  = gnt_w ? aw_addr_i : ar_addr_i;
    assign sel_size  = gnt_w ? aw_size_i : ar_size_i;
    assign sel_burst = hb_burst_e'(gnt_w ? aw_burst_i : ar_burst_i);

    assign trans_valid_o = cmd_valid_q;
    assign trans_hs      = cmd_valid_q & trans_ready_i;

    // op_q doubles as the last grant, so READ after reset lets write win
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cmd_valid_q <= 1'b0;
            op_q        <= HB_OP_READ;
        end else if (ax_hs) begin
            cmd_valid_q <= 1'b1;
            op_q        <= gnt_w ? HB_OP_WRITE : HB_OP_READ;
        end else if (trans_hs) begin
            cmd_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (ax_hs) begin
            addr_q <= sel_addr;
            len_q  <= gnt_w ? aw_len_i : ar_len_i;
            size_q <= sel_size;
        end
    end

    // ========================================
    // Descriptor
    // ========================================

    assign beats    = {1'b0, len_q} + 9'd1;
    assign chip_idx = (addr_q >> ChipAddrBits) % NumChips;

    always_comb begin
        for (int unsigned i = 0; i < NumChips; i++) begin
            trans_cs_o[i] = (chip_idx == i);
        end
    end

    assign trans_o.write         = (op_q == HB_OP_WRITE);
    assign trans_o.address_space = addr_space_i;
    // Linear bursts only
    assign trans_o.burst_type    = 1'b1;
    assign trans_o.address       = (addr_q & ~(32'hFFFF_FFFF << addr_mask_msb_i)) >> 1;
    assign trans_o.burst         = (size_q == 3'd2) ? hb_blen_t'(beats * WordsPerBeat)
                                                    : hb_blen_t'(beats);

    assign cmd.cmd_valid = cmd_valid_q;
    assign cmd.op        = op_q;
    assign cmd.size      = size_q;
    assign cmd.lane      = addr_q[1];
    assign cmd.beats     = beats;
    assign cmd.start     = trans_hs;

    // Only incrementing, size-aligned bursts are granted
    a_burst_incr : assert property (@(posedge clk_i) disable iff (!rst_ni)
        ax_hs |-> sel_burst == HB_BURST_INCR);
    a_addr_aligned : assert property (@(posedge clk_i) disable iff (!rst_ni)
        ax_hs |-> (sel_addr & ~(32'hFFFF_FFFF << sel_size)) == '0);

endmodule

/* hb_proto_pkg.sv */
// ========================================
// AXI and HyperBus protocol enums and
// the HyperBus transfer descriptor
// ========================================
package hb_proto_pkg;

    // Command type, also the arbiter's last grant
    typedef enum logic {
        HB_OP_READ  = 1'b0,
        HB_OP_WRITE = 1'b1
    } hb_op_e;

    // AXI response codes in use
    typedef enum logic [1:0] {
        HB_RESP_OKAY   = 2'b00,
        HB_RESP_SLVERR = 2'b10
    } hb_resp_e;

    // AXI burst encodings
    typedef enum logic [1:0] {
        HB_BURST_FIXED = 2'b00,
        HB_BURST_INCR  = 2'b01,
        HB_BURST_WRAP  = 2'b10
    } hb_burst_e;

    // Descriptor handed to the PHY
    typedef struct packed {
        logic                 write;
        logic                 address_space;
        logic                 burst_type;
        logic [31:0]          address;
        hb_cfg_pkg::hb_blen_t burst;
    } hb_trans_t;

endpackage

/* hb_rx_path.sv */
`timescale 1ns/1ps
// ========================================
// PHY word to AXI R beat packing
// ========================================
module hb_rx_path (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   rx_valid_i,
    output logic                   rx_ready_o,
    input  hb_cfg_pkg::phy_data_t  rx_data_i,
    input  logic                   rx_last_i,
    input  logic                   rx_error_i,
    output logic                   r_valid_o,
    input  logic                   r_ready_i,
    output hb_cfg_pkg::axi_data_t  r_data_o,
    output hb_proto_pkg::hb_resp_e r_resp_o,
    output logic                   r_last_o,
    hb_cmd_if.sink                 cmd
);
    import hb_cfg_pkg::*;
    import hb_proto_pkg::*;

    localparam int unsigned WordIdxW = $clog2(WordsPerBeat);
    typedef logic [WordIdxW-1:0] word_idx_t;

    logic       rd_active_q;
    logic       r_valid_q;
    logic       r_last_q;
    logic       err_q;
    logic       lane_q;
    word_idx_t  word_q;
    logic [8:0] beats_left_q;
    axi_data_t  data_q;
    logic       rx_hs;
    logic       full_beat;
    logic       beat_done;
    word_idx_t  pos;

    assign full_beat = (cmd.size == 3'd2);
    // Full beats fill low half first, halfword beats follow the lane
    assign pos       = full_beat ? word_q : word_idx_t'(lane_q);
    assign beat_done = full_beat ? (word_q == word_idx_t'(WordsPerBeat - 1)) : 1'b1;

    // Hold the PHY while an R beat waits
    assign rx_ready_o = rd_active_q & ~r_valid_q;
    assign rx_hs      = rx_valid_i & rx_ready_o;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_active_q  <= 1'b0;
            r_valid_q    <= 1'b0;
            r_last_q     <= 1'b0;
            err_q        <= 1'b0;
            lane_q       <= 1'b0;
            word_q       <= '0;
            beats_left_q <= '0;
        end else begin
            if (r_valid_q && r_ready_i) begin
                r_valid_q <= 1'b0;
            end
            if (cmd.start && cmd.op == HB_OP_READ) begin
                rd_active_q  <= 1'b1;
                lane_q       <= cmd.lane;
                word_q       <= '0;
                beats_left_q <= cmd.beats;
            end else if (rx_hs) begin
                rd_active_q <= ~rx_last_i;
                // Error sticks for the rest of the beat
                err_q       <= rx_error_i | (err_q & (word_q != '0));
                if (beat_done) begin
                    r_valid_q    <= 1'b1;
                    r_last_q     <= (beats_left_q == 9'd1);
                    beats_left_q <= beats_left_q - 9'd1;
                    word_q       <= '0;
                    lane_q       <= full_beat ? lane_q : ~lane_q;
                end else begin
                    word_q <= word_q + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rx_hs) begin
            data_q[pos*PhyWidth +: PhyWidth] <= rx_data_i;
        end
    end

    assign r_valid_o = r_valid_q;
    assign r_data_o  = data_q;
    assign r_last_o  = r_last_q;
    assign r_resp_o  = err_q ? HB_RESP_SLVERR : HB_RESP_OKAY;

    // PHY words only arrive for a read command
    a_rx_in_read : assert property (@(posedge clk_i) disable iff (!rst_ni)
        rx_hs |-> cmd.op == HB_OP_READ);

endmodule

/* hb_trans_ctrl.sv */
`timescale 1ns/1ps
// ========================================
// Transfer-active and write-enable state
// ========================================
module hb_trans_ctrl (
    input  logic   clk_i,
    input  logic   rst_ni,
    input  logic   rx_done_i,
    input  logic   tx_done_i,
    input  logic   b_done_i,
    output logic   busy_o,
    output logic   wr_en_o,
    hb_cmd_if.sink cmd
);
    import hb_proto_pkg::*;

    logic busy_q;
    logic busy_d;
    logic wr_en_q;
    logic wr_en_d;

    // Set overrules clear
    always_comb begin
        busy_d  = busy_q;
        wr_en_d = wr_en_q;
        if (rx_done_i || b_done_i) begin
            busy_d = 1'b0;
        end
        if (cmd.start) begin
            busy_d = 1'b1;
        end
        if (tx_done_i) begin
            wr_en_d = 1'b0;
        end
        if (cmd.start && cmd.op == HB_OP_WRITE) begin
            wr_en_d = 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            busy_q  <= 1'b0;
            wr_en_q <= 1'b0;
        end else begin
            busy_q  <= busy_d;
            wr_en_q <= wr_en_d;
        end
    end

    assign busy_o  = busy_q;
    assign wr_en_o = wr_en_q;

    // The PHY completes nothing while a command still waits for it
    a_no_done_when_held : assert property (@(posedge clk_i) disable iff (!rst_ni)
        (rx_done_i || b_done_i) |-> !cmd.cmd_valid);

endmodule

/* hb_tx_path.sv */
`timescale 1ns/1ps
// ========================================
// AXI W beat to PHY word splitting
// ========================================
module hb_tx_path (
    input  logic                                     clk_i,
    input  logic                                     rst_ni,
    input  logic                                     w_valid_i,
    output logic                                     w_ready_o,
    input  hb_cfg_pkg::axi_data_t                    w_data_i,
    input  logic [hb_cfg_pkg::AxiDataWidth/8-1:0]    w_strb_i,
    input  logic                                     w_last_i,
    output logic                                     tx_valid_o,
    input  logic                                     tx_ready_i,
    output hb_cfg_pkg::phy_data_t                    tx_data_o,
    output hb_cfg_pkg::phy_strb_t                    tx_strb_o,
    output logic                                     tx_last_o,
    input  logic                                     wr_en_i,
    hb_cmd_if.sink                                   cmd
);
    import hb_cfg_pkg::*;

    localparam int unsigned WordIdxW = $clog2(WordsPerBeat);
    localparam int unsigned StrbW    = PhyWidth / 8;
    typedef logic [WordIdxW-1:0] word_idx_t;

    logic                      full_q;
    logic                      last_q;
    logic                      lane_q;
    word_idx_t                 word_q;
    logic [8:0]                beats_left_q;
    axi_data_t                 data_q;
    logic [AxiDataWidth/8-1:0] strb_q;
    logic                      w_hs;
    logic                      tx_hs;
    logic                      full_beat;
    logic                      final_word;
    word_idx_t                 pos;

    assign full_beat  = (cmd.size == 3'd2);
    assign pos        = full_beat ? word_q : word_idx_t'(lane_q);
    assign final_word = full_beat ? (word_q == word_idx_t'(WordsPerBeat - 1)) : 1'b1;

    // One beat buffer, refilled once all its words are out
    assign w_ready_o  = wr_en_i & ~full_q;
    assign w_hs       = w_valid_i & w_ready_o;
    assign tx_valid_o = full_q;
    assign tx_hs      = full_q & tx_ready_i;

    assign tx_data_o = data_q[pos*PhyWidth +: PhyWidth];
    assign tx_strb_o = strb_q[pos*StrbW +: StrbW];
    assign tx_last_o = last_q & final_word;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            full_q       <= 1'b0;
            last_q       <= 1'b0;
            lane_q       <= 1'b0;
            word_q       <= '0;
            beats_left_q <= '0;
        end else if (cmd.start) begin
            lane_q       <= cmd.lane;
            word_q       <= '0;
            beats_left_q <= cmd.beats;
        end else if (w_hs) begin
            full_q       <= 1'b1;
            last_q       <= w_last_i;
            word_q       <= '0;
            beats_left_q <= beats_left_q - 9'd1;
        end else if (tx_hs) begin
            if (final_word) begin
                full_q <= 1'b0;
                lane_q <= full_beat ? lane_q : ~lane_q;
            end else begin
                word_q <= word_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (w_hs) begin
            data_q <= w_data_i;
            strb_q <= w_strb_i;
        end
    end

    // W last must match the AW burst length
    a_w_last_len : assert property (@(posedge clk_i) disable iff (!rst_ni)
        w_hs |-> w_last_i == (beats_left_q == 9'd1));

endmodule

/* tb_hb_tasks.svh */
// ========================================
// Directed tests and bus helper tasks
// ========================================
`ifndef TB_HB_TASKS_SVH
`define TB_HB_TASKS_SVH

task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] exp);
    $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
    err_cnt++;
endtask

task automatic finish_test(string name, int start_errs);
    test_cnt++;
    if (err_cnt == start_errs) begin
        $display("%s: ok", name);
    end else begin
        $display("%s: FAILED", name);
        test_fail++;
    end
endtask

// Byte address masked above msb and turned into a 16-bit word address
function automatic logic [31:0] word_addr(axi_addr_t addr, int msb);
    return (addr & ((32'h1 << msb) - 32'h1)) >> 1;
endfunction

task automatic ar_cmd(axi_addr_t addr, logic [7:0] len, logic [2:0] size);
    ar_valid_i = 1'b1;
    ar_addr_i = addr;
    ar_len_i = len;
    ar_size_i = size;
    do @(posedge clk_i); while (!ar_ready_o);
    #1 ar_valid_i = 1'b0;
endtask

task automatic aw_cmd(axi_addr_t addr, logic [7:0] len, logic [2:0] size);
    aw_valid_i = 1'b1;
    aw_addr_i = addr;
    aw_len_i = len;
    aw_size_i = size;
    do @(posedge clk_i); while (!aw_ready_o);
    #1 aw_valid_i = 1'b0;
endtask

task automatic send_w(axi_data_t data, logic [3:0] strb, logic last);
    w_valid_i = 1'b1;
    w_data_i = data;
    w_strb_i = strb;
    w_last_i = last;
    do @(posedge clk_i); while (!w_ready_o);
    #1 w_valid_i = 1'b0;
endtask

task automatic wait_b(hb_resp_e exp);
    b_ready_i = 1'b0;
    do @(posedge clk_i); while (!b_valid_o);
    if (b_resp_o !== exp) report_mismatch("b_resp_o", 32'(b_resp_o), 32'(exp));
    // A stalled B keeps the transfer open
    if (b_ready_o !== 1'b0) report_mismatch("b_ready_o", 32'(b_ready_o), 0);
    if (trans_active_o !== 1'b1)
        report_mismatch("trans_active_o", 32'(trans_active_o), 1);
    #1 b_ready_i = 1'b1;
    @(posedge clk_i);
    if (b_ready_o !== 1'b1) report_mismatch("b_ready_o", 32'(b_ready_o), 1);
    #1;
endtask

task automatic wait_idle();
    do @(posedge clk_i); while (trans_active_o || trans_valid_o);
    #1;
endtask

// Full-size beats with words packed low half first
task automatic collect_read(int n, phy_data_t base, int err_beat);
    axi_data_t exp;
    hb_resp_e exp_resp;
    for (int b = 0; b < n; b++) begin
        do @(posedge clk_i); while (!r_valid_o);
        exp = {base + 16'(2 * b + 1), base + 16'(2 * b)};
        exp_resp = (b == err_beat) ? HB_RESP_SLVERR : HB_RESP_OKAY;
        if (r_data_o !== exp) report_mismatch("r_data_o", r_data_o, exp);
        if (r_last_o !== (b == n - 1))
            report_mismatch("r_last_o", 32'(r_last_o), 32'(b == n - 1));
        if (r_resp_o !== exp_resp)
            report_mismatch("r_resp_o", 32'(r_resp_o), 32'(exp_resp));
        // The read ends on its last PHY word, before the last R beat is seen
        if (trans_active_o !== (b != n - 1))
            report_mismatch("trans_active_o", 32'(trans_active_o), 32'(b != n - 1));
    end
    #1;
endtask

task automatic word_read();
    int start = err_cnt;
    ar_cmd(32'h0010_0040, 8'd3, 3'd2);
    @(posedge clk_i);
    if (!trans_valid_o) report_mismatch("trans_valid_o", 32'(trans_valid_o), 32'd1);
    @(posedge clk_i);
    if (!trans_active_o) report_mismatch("trans_active_o", 32'(trans_active_o), 32'd1);
    if (got_trans.burst !== 16'd8) report_mismatch("trans_o.burst", 32'(got_trans.burst), 8);
    if (got_trans.address !== word_addr(32'h0010_0040, 20))
        report_mismatch("trans_o.address", got_trans.address, word_addr(32'h0010_0040, 20));
    if (got_trans.burst_type !== 1'b1)
        report_mismatch("trans_o.burst_type", 32'(got_trans.burst_type), 1);
    if (got_trans.address_space !== 1'b0)
        report_mismatch("trans_o.address_space", 32'(got_trans.address_space), 0);
    if (got_cs !== 2'b10) report_mismatch("trans_cs_o", 32'(got_cs), 32'h2);
    #1;
    collect_read(4, 16'h0020, -1);
    wait_idle();
    finish_test("word read", start);
endtask

task automatic halfword_write();
    int start = err_cnt;
    axi_data_t wd[3];
    logic [3:0] ws[3];
    int lane;
    tx_data_q.delete();
    tx_strb_q.delete();
    tx_last_q.delete();
    aw_cmd(32'h0000_0002, 8'd2, 3'd1);
    for (int i = 0; i < 3; i++) begin
        wd[i] = $random(seed);
        ws[i] = 4'($random(seed));
        send_w(wd[i], ws[i], i == 2);
    end
    wait_b(HB_RESP_OKAY);
    if (got_trans.burst !== 16'd3) report_mismatch("trans_o.burst", 32'(got_trans.burst), 3);
    if (got_trans.address !== 32'h1) report_mismatch("trans_o.address", got_trans.address, 1);
    if (tx_data_q.size() != 3) begin
        $display("Error: expected 3 tx words, saw %0d", tx_data_q.size());
        err_cnt++;
    end else begin
        for (int i = 0; i < 3; i++) begin
            // Start lane is address bit 1 and toggles per beat
            lane = (i % 2 == 0) ? 1 : 0;
            if (tx_data_q[i] !== wd[i][lane*16 +: 16])
                report_mismatch("tx_data_o", 32'(tx_data_q[i]), 32'(wd[i][lane*16 +: 16]));
            if (tx_strb_q[i] !== ws[i][lane*2 +: 2])
                report_mismatch("tx_strb_o", 32'(tx_strb_q[i]), 32'(ws[i][lane*2 +: 2]));
            if (tx_last_q[i] !== (i == 2))
                report_mismatch("tx_last_o", 32'(tx_last_q[i]), 32'(i == 2));
        end
    end
    wait_idle();
    finish_test("halfword write", start);
endtask

task automatic error_responses();
    int start = err_cnt;
    err_word = 16'd2;
    ar_cmd(32'h0000_0080, 8'd1, 3'd2);
    collect_read(2, 16'h0040, 1);
    wait_idle();
    err_word = 16'hFFFF;
    b_err_req = 1'b1;
    aw_cmd(32'h0000_0008, 8'd0, 3'd2);
    send_w($random(seed), 4'hF, 1'b1);
    wait_b(HB_RESP_SLVERR);
    wait_idle();
    b_err_req = 1'b0;
    finish_test("error responses", start);
endtask

task automatic arbitration_order();
    int start = err_cnt;
    op_hist.delete();
    ar_valid_i = 1'b1;
    ar_addr_i = 32'h0000_0100;
    ar_len_i = 8'd0;
    ar_size_i = 3'd2;
    aw_cmd(32'h0000_0200, 8'd0, 3'd2);
    send_w($random(seed), 4'hF, 1'b1);
    wait_b(HB_RESP_OKAY);
    do @(posedge clk_i); while (!ar_ready_o);
    #1 ar_valid_i = 1'b0;
    collect_read(1, 16'h0080, -1);
    wait_idle();
    if (op_hist.size() != 2) begin
        $display("Error: expected 2 transfers, saw %0d", op_hist.size());
        err_cnt++;
    end else begin
        if (op_hist[0] !== 1'b1) report_mismatch("trans_o.write", 32'(op_hist[0]), 1);
        if (op_hist[1] !== 1'b0) report_mismatch("trans_o.write", 32'(op_hist[1]), 0);
    end
    finish_test("arbitration", start);
endtask

task automatic status_backpressure();
    int start = err_cnt;
    addr_mask_msb_i = 5'd8;
    addr_space_i = 1'b1;
    r_ready_i = 1'b0;
    ar_cmd(32'h0000_0344, 8'd1, 3'd2);
    do @(posedge clk_i); while (!r_valid_o);
    repeat (4) begin
        @(posedge clk_i);
        if (rx_ready_o !== 1'b0) report_mismatch("rx_ready_o", 32'(rx_ready_o), 0);
        if (trans_active_o !== 1'b1)
            report_mismatch("trans_active_o", 32'(trans_active_o), 1);
    end
    #1 r_ready_i = 1'b1;
    collect_read(2, 16'h0022, -1);
    if (got_trans.address !== word_addr(32'h0000_0344, 8))
        report_mismatch("trans_o.address", got_trans.address, word_addr(32'h0000_0344, 8));
    if (got_trans.address_space !== 1'b1)
        report_mismatch("trans_o.address_space", 32'(got_trans.address_space), 1);
    if (got_cs !== 2'b01) report_mismatch("trans_cs_o", 32'(got_cs), 1);
    wait_idle();
    addr_mask_msb_i = 5'd20;
    addr_space_i = 1'b0;
    finish_test("status and back-pressure", start);
endtask

`endif

/* tb_hb_axi_frontend.sv */
`timescale 1ns/1ps
// ========================================
// Testbench for the AXI to HyperBus front end
// Clock, reset, PHY model, test sequence
// ========================================
module tb_hb_axi_frontend;
    import hb_cfg_pkg::*;
    import hb_proto_pkg::*;

    // Limit well above the length of all tests together
    localparam int MaxCycles = 2000;

    logic clk_i = 1'b0;
    logic rst_ni;
    logic aw_valid_i, aw_ready_o, ar_valid_i, ar_ready_o;
    axi_addr_t aw_addr_i, ar_addr_i;
    logic [7:0] aw_len_i, ar_len_i;
    logic [2:0] aw_size_i, ar_size_i;
    logic [1:0] aw_burst_i, ar_burst_i;
    logic w_valid_i, w_ready_o, w_last_i;
    axi_data_t w_data_i, r_data_o;
    logic [3:0] w_strb_i;
    logic r_valid_o, r_ready_i, r_last_o, b_valid_o, b_ready_i;
    hb_resp_e r_resp_o, b_resp_o;
    logic rx_valid_i, rx_ready_o, rx_last_i, rx_error_i;
    phy_data_t rx_data_i, tx_data_o;
    logic tx_valid_o, tx_ready_i, tx_last_o;
    phy_strb_t tx_strb_o;
    logic b_valid_i, b_ready_o, b_error_i;
    hb_trans_t trans_o;
    logic [1:0] trans_cs_o;
    logic trans_valid_o, trans_ready_i;
    logic [4:0] addr_mask_msb_i;
    logic addr_space_i, trans_active_o;

    int seed = 32'hfb9c726c;
    int cycles = 0;
    int err_cnt = 0;
    int test_cnt = 0;
    int test_fail = 0;

    // PHY model state seen by the tests
    hb_trans_t got_trans;
    logic [1:0] got_cs;
    logic op_hist[$];
    phy_data_t tx_data_q[$];
    phy_strb_t tx_strb_q[$];
    logic tx_last_q[$];
    // Erroring word index or all ones for none
    logic [15:0] err_word = 16'hFFFF;
    logic b_err_req = 1'b0;

    always #5 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= MaxCycles) begin
            $display("Timeout: no progress after %0d cycles", cycles);
            $display("Regression failed");
            $finish;
        end
    end

    hb_axi_frontend i_dut (.*);

    // ========================================
    // PHY responder
    // ========================================
    initial begin : phy_model
        phy_data_t rd_base;
        hb_blen_t rd_len;
        logic [15:0] rd_idx;
        logic rd_on;
        logic b_start;
        logic b_hs;
        rd_on = 1'b0;
        rd_idx = '0;
        rd_len = '0;
        rd_base = '0;
        rx_valid_i = 1'b0;
        rx_data_i = '0;
        rx_last_i = 1'b0;
        rx_error_i = 1'b0;
        b_valid_i = 1'b0;
        b_error_i = 1'b0;
        forever begin
            @(posedge clk_i);
            b_start = 1'b0;
            if (trans_valid_o && trans_ready_i) begin
                got_trans = trans_o;
                got_cs = trans_cs_o;
                op_hist.push_back(trans_o.write);
                if (!trans_o.write) begin
                    rd_base = trans_o.address[15:0];
                    rd_len = trans_o.burst;
                    rd_idx = '0;
                    rd_on = 1'b1;
                end
            end
            if (rx_valid_i && rx_ready_o) begin
                rd_idx = rd_idx + 16'd1;
                if (rx_last_i) rd_on = 1'b0;
            end
            if (tx_valid_o && tx_ready_i) begin
                tx_data_q.push_back(tx_data_o);
                tx_strb_q.push_back(tx_strb_o);
                tx_last_q.push_back(tx_last_o);
                b_start = tx_last_o;
            end
            b_hs = b_valid_i && b_ready_o;
            #1;
            // Read word pattern is word address plus index
            rx_valid_i = rd_on;
            rx_data_i = rd_base + rd_idx;
            rx_last_i = rd_on && (rd_idx == rd_len - 16'd1);
            rx_error_i = rd_on && (rd_idx == err_word);
            if (b_hs) b_valid_i = 1'b0;
            if (b_start) begin
                b_valid_i = 1'b1;
                b_error_i = b_err_req;
            end
        end
    end

    `include "tb_hb_tasks.svh"

    // ========================================
    // Test sequence
    // ========================================
    initial begin
        rst_ni = 1'b0;
        {aw_valid_i, ar_valid_i, w_valid_i, w_last_i} = '0;
        {aw_addr_i, ar_addr_i, w_data_i} = '0;
        {aw_len_i, ar_len_i, aw_size_i, ar_size_i} = '0;
        aw_burst_i = 2'b01;
        ar_burst_i = 2'b01;
        w_strb_i = '0;
        r_ready_i = 1'b1;
        b_ready_i = 1'b1;
        tx_ready_i = 1'b1;
        trans_ready_i = 1'b1;
        addr_mask_msb_i = 5'd20;
        addr_space_i = 1'b0;
        repeat (3) @(posedge clk_i);
        #1 rst_ni = 1'b1;

        arbitration_order();
        word_read();
        halfword_write();
        error_responses();
        status_backpressure();

        $display("Summary: %0d tests, %0d failed, %0d check errors",
                 test_cnt, test_fail, err_cnt);
        if (err_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule
